//--- oscPkg.sv
package oscPkg;
	localparam int sampleW = 8;                  // one adc sample
	localparam int numCh = 4;                    // adc channels
	localparam int wordW = numCh * sampleW;      // memory word, all channels side by side
	localparam int axiAw = 8;                    // axi-lite address bits
	localparam int axiDw = 32;                   // axi-lite data bits

	localparam logic [1:0] respOkay = 2'b00;     // the only response this slave gives

	// sequencer states, also visible in the status register bits 2:1
	typedef enum logic [1:0] {
		idle,       // waiting for a start
		preAcq,     // filling the pre-trigger part
		waitTrig,   // storing and watching for the trigger
		postAcq     // storing the post-trigger part
	} acqState_t;

	typedef enum logic {
		rising,     // sample enters the window
		falling     // sample leaves the window
	} trigType_t;

	// register map, byte offsets
	localparam logic [axiAw-1:0] regCtrl = 8'h00;     // bit 0 starts an acquisition
	localparam logic [axiAw-1:0] regStatus = 8'h04;   // dataReady, state
	localparam logic [axiAw-1:0] regThresh = 8'h08;   // low 7:0, high 15:8
	localparam logic [axiAw-1:0] regTrig = 8'h0C;     // mask 3:0, type 4, downsample 12:8
	localparam logic [axiAw-1:0] regPre = 8'h10;      // pre-trigger word count
	localparam logic [axiAw-1:0] regPost = 8'h14;     // post-trigger word count
	localparam logic [axiAw-1:0] regTrigAddr = 8'h18; // captured trigger address, read only
	localparam logic [axiAw-1:0] memBase = 8'h80;     // sample window, relative to trigger
endpackage

//--- oscTrigger.sv
`timescale 1ns/1ps
module oscTrigger (
	input  logic                         clk_flash,
	input  logic                         arstN,
	input  logic [oscPkg::sampleW-1:0]   adc0,
	input  logic [oscPkg::sampleW-1:0]   adc1,
	input  logic [oscPkg::sampleW-1:0]   adc2,
	input  logic [oscPkg::sampleW-1:0]   adc3,
	input  logic [oscPkg::sampleW-1:0]   threshLow,
	input  logic [oscPkg::sampleW-1:0]   threshHigh,
	input  logic [oscPkg::numCh-1:0]     chMask,
	input  oscPkg::trigType_t            trigType,
	output logic [oscPkg::wordW-1:0]     sampleWord,
	output logic                         trigger
);
	import oscPkg::*;

	logic [wordW-1:0] adcWord;      // input register with channel c in bits c*sampleW
	logic [wordW-1:0] wordD1;       // word pipeline keeping pace with the flag pipeline
	logic [wordW-1:0] wordD2;
	logic [numCh-1:0] winNow;       // window compare on the registered inputs
	logic [numCh-1:0] inWin;        // in-window flag of the current sample
	logic [numCh-1:0] inWinPrev;    // same flag one sample earlier
	logic [numCh-1:0] chEdge;       // per-channel edge before the mask

	// sample word pipeline, three stages deep like the flag path
	always_ff @(posedge clk_flash) begin
		adcWord <= {adc3, adc2, adc1, adc0};  // edge k
		wordD1 <= adcWord;                    // k+1
		wordD2 <= wordD1;                     // k+2
		sampleWord <= wordD2;                 // k+3 on the same edge as its trigger bit
	end

	always_comb begin
		for (int c = 0; c < numCh; c++) begin
			winNow[c] = (adcWord[c*sampleW +: sampleW] >= threshLow) &&
				(adcWord[c*sampleW +: sampleW] <= threshHigh);  // inclusive on both ends
		end
	end

	always_ff @(posedge clk_flash or negedge arstN) begin
		if (!arstN) begin
			inWin <= '0;
			inWinPrev <= '0;
			chEdge <= '0;
			trigger <= 1'b0;
		end else begin
			inWin <= winNow;        // flag of sample k at k+1
			inWinPrev <= inWin;     // flag of sample k-1 at k+1
			if (trigType == rising) begin
				chEdge <= inWin & ~inWinPrev;   // came into the window
			end else begin
				chEdge <= ~inWin & inWinPrev;   // dropped out of the window
			end
			trigger <= |(chEdge & chMask);  // masked OR gives one pulse per edge
		end
	end
endmodule

//--- oscAcquire.sv
`timescale 1ns/1ps
module oscAcquire #(
	parameter int ramAw = 6
) (
	input  logic                         clk_flash,
	input  logic                         arstN,
	input  logic                         start,
	input  logic [4:0]                   downsample,
	input  logic [ramAw-1:0]             preCount,
	input  logic [ramAw-1:0]             postCount,
	input  logic [oscPkg::wordW-1:0]     sampleWord,
	input  logic                         trigger,
	output logic                         memWe,
	output logic [ramAw-1:0]             memWaddr,
	output logic [oscPkg::wordW-1:0]     memWdata,
	output logic [ramAw-1:0]             trigAddr,
	output logic                         dataReady,
	output oscPkg::acqState_t            state
);
	import oscPkg::*;

	logic [31:0]      dsCnt;      // free-running sample counter for the downsample tick
	logic [31:0]      dsMask;     // low downsample bits set
	logic             tick;       // this sample is one of every 2^downsample
	logic             store;      // write this word into the ring
	logic [ramAw-1:0] wrAddr;     // ring write pointer, wraps with the depth
	logic [ramAw-1:0] sampCnt;    // words stored in the current phase

	assign dsMask = (32'd1 << downsample) - 32'd1;
	assign tick = (dsCnt & dsMask) == dsMask;   // every sample when downsample is 0
	assign store = tick && (state != idle);

	assign memWe = store;
	assign memWaddr = wrAddr;
	assign memWdata = sampleWord;

	always_ff @(posedge clk_flash or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			dataReady <= 1'b0;
			dsCnt <= '0;
			wrAddr <= '0;
			sampCnt <= '0;
			trigAddr <= '0;
		end else begin
			dsCnt <= dsCnt + 32'd1;
			if (store) begin
				wrAddr <= wrAddr + 1'b1;
			end
			case (state)
				idle: begin
					if (start) begin  // a start anywhere else is ignored
						dataReady <= 1'b0;
						dsCnt <= '0;
						wrAddr <= '0;
						sampCnt <= '0;
						state <= (preCount == '0) ? waitTrig : preAcq;
					end
				end
				preAcq: begin
					if (tick) begin
						sampCnt <= sampCnt + 1'b1;
						if (sampCnt == preCount - 1'b1) begin
							state <= waitTrig;  // last pre-trigger word goes in now
						end
					end
				end
				waitTrig: begin
					if (tick && trigger) begin  // only a ticked word can trigger
						trigAddr <= wrAddr;     // address of the triggering word
						sampCnt <= ramAw'(1);   // the trigger word counts as post word 1
						if (postCount <= ramAw'(1)) begin
							dataReady <= 1'b1;
							state <= idle;
						end else begin
							state <= postAcq;
						end
					end
				end
				postAcq: begin
					if (tick) begin
						sampCnt <= sampCnt + 1'b1;
						if (sampCnt == postCount - 1'b1) begin
							dataReady <= 1'b1;  // final word written on this edge
							state <= idle;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end
endmodule

//--- oscSampleRam.sv
`timescale 1ns/1ps
module oscSampleRam #(
	parameter int ramAw = 6
) (
	input  logic                         clk_flash,
	input  logic                         we,
	input  logic [ramAw-1:0]             waddr,
	input  logic [oscPkg::wordW-1:0]     wdata,
	input  logic [ramAw-1:0]             raddr,
	output logic [oscPkg::wordW-1:0]     rdata
);
	import oscPkg::*;

	logic [wordW-1:0] mem [2**ramAw];  // ring of words with four channels each

	// one write port and one registered read port on the same clock
	always_ff @(posedge clk_flash) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];  // data one cycle after the address
	end
endmodule

//--- oscAxiRegs.sv
`timescale 1ns/1ps
module oscAxiRegs #(
	parameter int ramAw = 6
) (
	input  logic                           clk_flash,
	input  logic                           arstN,
	input  logic [oscPkg::axiAw-1:0]       awaddr,
	input  logic                           awvalid,
	output logic                           awready,
	input  logic [oscPkg::axiDw-1:0]       wdata,
	input  logic [oscPkg::axiDw/8-1:0]     wstrb,
	input  logic                           wvalid,
	output logic                           wready,
	output logic [1:0]                     bresp,
	output logic                           bvalid,
	input  logic                           bready,
	input  logic [oscPkg::axiAw-1:0]       araddr,
	input  logic                           arvalid,
	output logic                           arready,
	output logic [oscPkg::axiDw-1:0]       rdata,
	output logic [1:0]                     rresp,
	output logic                           rvalid,
	input  logic                           rready,
	output logic [oscPkg::sampleW-1:0]     threshLow,
	output logic [oscPkg::sampleW-1:0]     threshHigh,
	output logic [oscPkg::numCh-1:0]       chMask,
	output oscPkg::trigType_t              trigType,
	output logic                           start,
	output logic [4:0]                     downsample,
	output logic [ramAw-1:0]               preCount,
	output logic [ramAw-1:0]               postCount,
	input  logic                           dataReady,
	input  oscPkg::acqState_t              state,
	input  logic [ramAw-1:0]               trigAddr,
	output logic [ramAw-1:0]               memRaddr,
	input  logic [oscPkg::wordW-1:0]       memRdata
);
	import oscPkg::*;

	localparam int offW = axiAw - 3;  // word offset bits inside the 128-byte window

	logic [axiAw-1:0]   awAddrQ;    // held write address
	logic [axiDw-1:0]   wDataQ;     // held write data
	logic [axiDw/8-1:0] wStrbQ;
	logic               awHave;     // write address arrived
	logic               wHave;      // write data arrived
	logic               doWrite;    // both halves present, update this cycle
	logic [axiDw-1:0]   wrImage;    // target register after the byte merge
	logic [axiAw-1:0]   arAddrQ;    // held read address
	logic [1:0]         rdPipe;     // memory cycle, then output register cycle
	logic               rdBusy;
	logic [axiDw-1:0]   rdImage;

	// current contents as seen from the bus, zero outside the map
	function automatic logic [axiDw-1:0] regImage(input logic [axiAw-1:0] addr);
		logic [axiDw-1:0] img;
		img = '0;
		case (addr)
			regStatus: begin
				img[0] = dataReady;
				img[2:1] = state;
			end
			regThresh: img[15:0] = {threshHigh, threshLow};
			regTrig: begin
				img[numCh-1:0] = chMask;
				img[4] = trigType;
				img[12:8] = downsample;
			end
			regPre: img[ramAw-1:0] = preCount;
			regPost: img[ramAw-1:0] = postCount;
			regTrigAddr: img[ramAw-1:0] = trigAddr;
			default: begin
				if (addr >= memBase) begin
					img = memRdata;
				end
			end
		endcase
		return img;
	endfunction

	function automatic logic [axiDw-1:0] mergeStrb(input logic [axiDw-1:0] old,
		input logic [axiDw-1:0] data, input logic [axiDw/8-1:0] strb);
		logic [axiDw-1:0] res;
		res = old;
		for (int b = 0; b < axiDw/8; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = data[8*b +: 8];  // only strobed bytes change
			end
		end
		return res;
	endfunction

	assign doWrite = awHave && wHave;
	assign rdBusy = (|rdPipe) || rvalid;
	assign bresp = respOkay;
	assign rresp = respOkay;

	// signed word offset, so the window reaches before the trigger too
	assign memRaddr = trigAddr + ramAw'($signed(arAddrQ[offW+1:2]));

	always_comb wrImage = mergeStrb(regImage(awAddrQ), wDataQ, wStrbQ);
	always_comb rdImage = regImage(arAddrQ);

	always_ff @(posedge clk_flash or negedge arstN) begin
		if (!arstN) begin
			awready <= 1'b0;
			wready <= 1'b0;
			awHave <= 1'b0;
			wHave <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (awvalid && awready) begin
				awHave <= 1'b1;
				awready <= 1'b0;
			end else if (doWrite) begin
				awHave <= 1'b0;
			end else if (!awHave && !bvalid) begin
				awready <= 1'b1;  // reopen after the response is taken
			end
			if (wvalid && wready) begin
				wHave <= 1'b1;
				wready <= 1'b0;
			end else if (doWrite) begin
				wHave <= 1'b0;
			end else if (!wHave && !bvalid) begin
				wready <= 1'b1;
			end
			if (doWrite) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_flash) begin
		if (awvalid && awready) begin
			awAddrQ <= awaddr;
		end
		if (wvalid && wready) begin
			wDataQ <= wdata;
			wStrbQ <= wstrb;
		end
	end

	always_ff @(posedge clk_flash or negedge arstN) begin
		if (!arstN) begin
			threshLow <= '0;
			threshHigh <= '0;
			chMask <= '0;
			trigType <= rising;
			downsample <= '0;
			preCount <= '0;
			postCount <= '0;
			start <= 1'b0;
		end else begin
			start <= doWrite && (awAddrQ == regCtrl) && wStrbQ[0] && wDataQ[0];  // one cycle
			if (doWrite) begin
				case (awAddrQ)
					regThresh: begin
						threshLow <= wrImage[7:0];
						threshHigh <= wrImage[15:8];
					end
					regTrig: begin
						chMask <= wrImage[numCh-1:0];
						trigType <= trigType_t'(wrImage[4]);
						downsample <= wrImage[12:8];
					end
					regPre: preCount <= wrImage[ramAw-1:0];
					regPost: postCount <= wrImage[ramAw-1:0];
					default: ;  // read-only and unmapped writes are dropped
				endcase
			end
		end
	end

	always_ff @(posedge clk_flash or negedge arstN) begin
		if (!arstN) begin
			arready <= 1'b0;
			rdPipe <= '0;
			rvalid <= 1'b0;
		end else begin
			rdPipe <= {rdPipe[0], arvalid && arready};
			if (arvalid && arready) begin
				arready <= 1'b0;  // one read in flight at a time
			end else if (!rdBusy) begin
				arready <= 1'b1;
			end
			if (rdPipe[1]) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_flash) begin
		if (arvalid && arready) begin
			arAddrQ <= araddr;
		end
		if (rdPipe[1]) begin
			rdata <= rdImage;  // memory word valid by now
		end
	end
endmodule

//--- oscTop.sv
`timescale 1ns/1ps
module oscTop #(
	parameter int ramAw = 6
) (
	input  logic                           clk_flash,
	input  logic                           arstN,
	input  logic [oscPkg::sampleW-1:0]     adc0,
	input  logic [oscPkg::sampleW-1:0]     adc1,
	input  logic [oscPkg::sampleW-1:0]     adc2,
	input  logic [oscPkg::sampleW-1:0]     adc3,
	input  logic [oscPkg::axiAw-1:0]       awaddr,
	input  logic                           awvalid,
	output logic                           awready,
	input  logic [oscPkg::axiDw-1:0]       wdata,
	input  logic [oscPkg::axiDw/8-1:0]     wstrb,
	input  logic                           wvalid,
	output logic                           wready,
	output logic [1:0]                     bresp,
	output logic                           bvalid,
	input  logic                           bready,
	input  logic [oscPkg::axiAw-1:0]       araddr,
	input  logic                           arvalid,
	output logic                           arready,
	output logic [oscPkg::axiDw-1:0]       rdata,
	output logic [1:0]                     rresp,
	output logic                           rvalid,
	input  logic                           rready
);
	import oscPkg::*;

	logic [sampleW-1:0] threshLow, threshHigh;  // window limits
	logic [numCh-1:0]   chMask;
	trigType_t          trigType;
	logic               start;                  // one-cycle pulse from the ctrl write
	logic [4:0]         downsample;
	logic [ramAw-1:0]   preCount, postCount;
	logic [wordW-1:0]   sampleWord;             // aligned with trigger
	logic               trigger;
	logic               memWe;
	logic [ramAw-1:0]   memWaddr, memRaddr, trigAddr;
	logic [wordW-1:0]   memWdata, memRdata;
	logic               dataReady;
	acqState_t          state;

	oscTrigger uTrigger (
		.clk_flash, .arstN, .adc0, .adc1, .adc2, .adc3,
		.threshLow, .threshHigh, .chMask, .trigType,
		.sampleWord, .trigger
	);

	oscAcquire #(.ramAw(ramAw)) uAcquire (
		.clk_flash, .arstN, .start, .downsample, .preCount, .postCount,
		.sampleWord, .trigger, .memWe, .memWaddr, .memWdata,
		.trigAddr, .dataReady, .state
	);

	oscSampleRam #(.ramAw(ramAw)) uSampleRam (
		.clk_flash, .we(memWe), .waddr(memWaddr), .wdata(memWdata),
		.raddr(memRaddr), .rdata(memRdata)
	);

	oscAxiRegs #(.ramAw(ramAw)) uAxiRegs (
		.clk_flash, .arstN,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.threshLow, .threshHigh, .chMask, .trigType, .start, .downsample,
		.preCount, .postCount, .dataReady, .state, .trigAddr,
		.memRaddr, .memRdata
	);
endmodule

//--- oscTbModel.svh
`ifndef OSC_TB_MODEL_SVH
`define OSC_TB_MODEL_SVH

// xorshift32 step, never reaches zero from a nonzero seed
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// adc pattern for one counter value, channel c sits 16*c above the counter
function automatic logic [31:0] refWord(input logic [7:0] cnt);
	logic [31:0] w;
	w = '0;
	for (int c = 0; c < 4; c++) begin
		w[c*8 +: 8] = cnt + 8'(16 * c);  // wraps mod 256
	end
	return w;
endfunction

function automatic logic inWindow(input logic [7:0] s, input logic [7:0] lo,
	input logic [7:0] hi);
	return (lo <= s) && (s <= hi);  // both limits inclusive
endfunction

// cur triggers when a masked channel enters (rising) or leaves (falling) the window
function automatic logic isTrigger(input logic [31:0] prev, input logic [31:0] cur,
	input logic [7:0] lo, input logic [7:0] hi, input logic fall, input logic [3:0] mask);
	logic hit;
	logic inPrev;
	logic inCur;
	hit = 1'b0;
	for (int c = 0; c < 4; c++) begin
		inPrev = inWindow(prev[c*8 +: 8], lo, hi);
		inCur = inWindow(cur[c*8 +: 8], lo, hi);
		if (mask[c] && (fall ? (inPrev && !inCur) : (inCur && !inPrev))) begin
			hit = 1'b1;
		end
	end
	return hit;
endfunction

`endif

//--- oscTb.sv
`timescale 1ns/1ps
module oscTb;
	import oscPkg::*;

	`include "oscTbModel.svh"

	localparam logic [axiAw-1:0] cfgAddr [4] = '{regThresh, regTrig, regPre, regPost};
	localparam logic [axiDw-1:0] cfgBits [4] = '{32'h0000_FFFF, 32'h0000_1F1F,
		32'h0000_003F, 32'h0000_003F};  // implemented bits per register

	logic clk_flash = 1'b0;
	logic arstN;
	logic [sampleW-1:0] adc0 = '0;
	logic [sampleW-1:0] adc1 = '0;
	logic [sampleW-1:0] adc2 = '0;
	logic [sampleW-1:0] adc3 = '0;
	logic [axiAw-1:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [axiDw-1:0] wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;
	logic [7:0] n = '0;            // ramp counter behind the adc pattern
	logic [1:0] holdLeft = '0;     // cycles n stays frozen
	logic [31:0] rngAdc = 32'h949a;
	logic [31:0] rngCfg;
	logic freezeOn;                // random holds on the ramp
	int cycleCnt = 0;
	logic [axiDw-1:0] expVal [$];  // one entry per read in flight
	logic [axiDw-1:0] expMask [$];
	logic [axiAw-1:0] expAddr [$];

	oscTop #(.ramAw(6)) DUT (.*);

	always #10 clk_flash = ~clk_flash;  // 20 ns period

	always @(posedge clk_flash) cycleCnt <= cycleCnt + 1;

	always @(posedge clk_flash) begin : adcDrive
		logic [7:0] nNext;
		logic [31:0] w;
		nNext = n;
		if (holdLeft != 2'd0) begin
			holdLeft <= holdLeft - 2'd1;
		end else begin
			nNext = n + 8'd1;
			if (freezeOn) begin
				rngAdc <= xorshift(rngAdc);
				holdLeft <= 2'(rngAdc % 32'd3);  // 0 to 2 extra cycles
			end else if (nNext == 8'd200) begin
				holdLeft <= 2'd1;  // one-sample slip shifts the ramp against the downsample tick
			end
		end
		w = refWord(nNext);
		n <= nNext;
		adc0 <= w[7:0];
		adc1 <= w[15:8];
		adc2 <= w[23:16];
		adc3 <= w[31:24];
	end

	task automatic failRun();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	always @(posedge clk_flash) begin : compareReads
		logic [31:0] e;
		logic [31:0] m;
		logic [7:0] a;
		if (bvalid && bready) begin
			assert (bresp == 2'b00) else begin
				$display("** Error bresp: expected %h, got %h", 2'b00, bresp);
				failRun();
			end
		end
		if (rvalid && rready) begin
			assert (rresp == 2'b00) else begin
				$display("** Error rresp: expected %h, got %h", 2'b00, rresp);
				failRun();
			end
			if (expVal.size() == 0) begin
				$display("read data came back with no read outstanding");
				failRun();
			end else begin
				e = expVal.pop_front();
				m = expMask.pop_front();
				a = expAddr.pop_front();
				assert ((rdata & m) == (e & m)) else begin
					$display("** Error rdata at %h: expected %h, got %h", a, e & m, rdata & m);
					failRun();
				end
			end
		end
	end

	function automatic logic [axiAw-1:0] memAddr(input int k);
		return memBase | {1'b0, 5'(k), 2'b00};  // signed word offset from the trigger
	endfunction

	task automatic axiWrite(input logic [axiAw-1:0] addr, input logic [axiDw-1:0] data,
		input logic [3:0] strb);
		int t;
		t = 0;
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= strb;
		wvalid <= 1'b1;
		bready <= 1'b1;
		do begin
			@(posedge clk_flash);
			t++;
			if (awvalid && awready) begin
				awvalid <= 1'b0;
			end
			if (wvalid && wready) begin
				wvalid <= 1'b0;
			end
			if (t > 50) begin
				$display("write to %h never got its response", addr);
				failRun();
			end
		end while (!(bvalid && bready));
		bready <= 1'b0;
	endtask

	// m selects the bits the compare process checks and is zero for a plain read
	task automatic axiRead(input logic [axiAw-1:0] addr, input logic [axiDw-1:0] e,
		input logic [axiDw-1:0] m, output logic [axiDw-1:0] data);
		int t;
		expVal.push_back(e);
		expMask.push_back(m);
		expAddr.push_back(addr);
		araddr <= addr;
		arvalid <= 1'b1;
		t = 0;
		do begin
			@(posedge clk_flash);
			t++;
			if (t > 50) begin
				$display("read address %h was never accepted", addr);
				failRun();
			end
		end while (!arready);
		arvalid <= 1'b0;
		rready <= 1'b1;
		t = 0;
		do begin
			@(posedge clk_flash);
			t++;
			if (t > 50) begin
				$display("no read data came back for %h", addr);
				failRun();
			end
		end while (!rvalid);
		data = rdata;
		rready <= 1'b0;
	endtask

	task automatic readCheck(input logic [axiAw-1:0] addr, input logic [axiDw-1:0] e,
		input logic [axiDw-1:0] m);
		logic [axiDw-1:0] unused;
		axiRead(addr, e, m, unused);
	endtask

	task automatic startAcq(input logic [7:0] lo, input logic [7:0] hi,
		input logic [31:0] trig, input int pre, input int post);
		axiWrite(regThresh, {16'd0, hi, lo}, 4'hF);
		axiWrite(regTrig, trig, 4'hF);
		axiWrite(regPre, 32'(pre), 4'hF);
		axiWrite(regPost, 32'(post), 4'hF);
		axiWrite(regCtrl, 32'd1, 4'hF);
	endtask

	task automatic waitReady(input int limit);
		int t0;
		logic [31:0] st;
		t0 = cycleCnt;
		st = '0;
		while (!st[0]) begin
			if (cycleCnt - t0 > limit) begin
				$display("dataReady did not rise within %0d cycles", limit);
				failRun();
			end
			axiRead(regStatus, '0, '0, st);
		end
	endtask

	// word 0 must form the edge against the stored word before it
	task automatic checkTrigPair(input logic [7:0] lo, input logic [7:0] hi,
		input logic fall, input logic [3:0] mask);
		logic [31:0] prev;
		logic [31:0] cur;
		axiRead(memAddr(-1), '0, '0, prev);
		axiRead(memAddr(0), '0, '0, cur);
		assert (isTrigger(prev, cur, lo, hi, fall, mask)) else begin
			$display("stored words %h then %h do not form the trigger edge", prev, cur);
			failRun();
		end
	endtask

	task automatic checkWindow(input logic [7:0] base, input int step, input int pre,
		input int post);
		for (int k = -pre; k < post; k++) begin
			readCheck(memAddr(k), refWord(8'(int'(base) + step * k)), 32'hFFFF_FFFF);
		end
	endtask

	initial begin : stimulus
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] want;
		logic [3:0] strb;
		int t0;
		arstN = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		freezeOn = 1'b1;
		rngCfg = xorshift(32'h949a);
		repeat (2) @(posedge clk_flash);
		arstN <= 1'b1;
		@(posedge clk_flash);

		readCheck(regStatus, 32'(idle) << 1, 32'h7);  // not ready and idle
		readCheck(regTrigAddr, '0, 32'hFFFF_FFFF);
		readCheck(8'h1C, '0, 32'hFFFF_FFFF);          // unmapped

		for (int i = 0; i < 4; i++) begin
			rngCfg = xorshift(rngCfg);
			v1 = rngCfg;
			axiWrite(cfgAddr[i], v1, 4'hF);
			readCheck(cfgAddr[i], v1 & cfgBits[i], 32'hFFFF_FFFF);
			rngCfg = xorshift(rngCfg);
			v2 = rngCfg;
			rngCfg = xorshift(rngCfg);
			strb = rngCfg[3:0];
			want = v1;
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					want[8*b +: 8] = v2[8*b +: 8];  // strobed byte takes the new data
				end
			end
			axiWrite(cfgAddr[i], v2, strb);
			readCheck(cfgAddr[i], want & cfgBits[i], 32'hFFFF_FFFF);
		end

		freezeOn <= 1'b0;
		startAcq(8'd100, 8'd120, 32'h0000_0001, 8, 16);  // rising on ch0 without downsampling
		waitReady(4000);
		checkTrigPair(8'd100, 8'd120, 1'b0, 4'b0001);
		checkWindow(8'd100, 1, 8, 16);  // ch0 enters the window at the low limit

		freezeOn <= 1'b1;
		startAcq(8'd100, 8'd120, 32'h0000_0014, 4, 4);  // falling on ch2
		waitReady(4000);
		checkTrigPair(8'd100, 8'd120, 1'b1, 4'b0100);

		freezeOn <= 1'b0;
		startAcq(8'd100, 8'd120, 32'h0000_0201, 8, 16);  // one word in four
		waitReady(4000);
		checkTrigPair(8'd100, 8'd120, 1'b0, 4'b0001);
		checkWindow(8'd100, 4, 8, 16);  // only a ticked 100 can follow a 99

		startAcq(8'd100, 8'd120, 32'h0000_0000, 0, 4);  // empty mask never triggers
		t0 = cycleCnt;
		while (cycleCnt - t0 < 2000) begin
			readCheck(regStatus, 32'(waitTrig) << 1, 32'h7);
		end
		$display("empty mask held waitTrig for 2000 cycles, as expected");

		$display("PASS: all tests");
		$finish;
	end
endmodule

//--- sources.f
+incdir+.
oscPkg.sv
oscTrigger.sv
oscAcquire.sv
oscSampleRam.sv
oscAxiRegs.sv
oscTop.sv
oscTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module oscTb -f sources.f -o oscSim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/oscSim > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log && exit 0 || exit 1
